// ==== frontend_top.f ====
source/frontend_pkg.sv
source/fetch_if.sv
source/decode_if.sv
source/icache.sv
source/instr_queue.sv
source/decoder.sv
source/frontend_top.sv
test/frontend_checker.sv
test/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the front end testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f frontend_top.f \
    --top-module frontend_tb \
    --Mdir obj_dir \
    -o frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
    exit 0
fi
exit 1

// ==== source/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;

    // Oldest queue entry, shown without a register stage.
    logic                 empty;
    frontend_pkg::pc_t    head_pc;
    frontend_pkg::instr_t head_instr;

    // Head advances on the edge that sees pop.
    logic                 pop;

    modport queue (output empty, output head_pc, output head_instr, input pop);

    modport dec (input empty, input head_pc, input head_instr, output pop);

endinterface

// ==== source/decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      redirect,
    input  logic                      issue_ready,
    decode_if.dec                     deq,
    output logic                      dec_valid,
    output frontend_pkg::pc_t         dec_pc,
    output frontend_pkg::op_class_e   dec_class,
    output frontend_pkg::reg_idx_t    dec_rd,
    output frontend_pkg::reg_idx_t    dec_rs1,
    output frontend_pkg::reg_idx_t    dec_rs2,
    output frontend_pkg::imm_t        dec_imm
);

    frontend_pkg::instr_t      w;
    frontend_pkg::op_class_e   cls;
    frontend_pkg::imm_t        imm;

    assign w       = deq.head_instr;
    assign deq.pop = !deq.empty && (!dec_valid || issue_ready);

    // ######################################
    // Classify and build the immediate
    // ######################################
    always_comb begin
        // Every valid opcode ends in 11, so the default also catches bad low bits.
        case (w[6:0])
            frontend_pkg::OPC_OP:     cls = frontend_pkg::alu_reg;
            frontend_pkg::OPC_OP_IMM: cls = frontend_pkg::alu_imm;
            frontend_pkg::OPC_LOAD:   cls = frontend_pkg::load;
            frontend_pkg::OPC_STORE:  cls = frontend_pkg::store;
            frontend_pkg::OPC_BRANCH: cls = frontend_pkg::branch;
            frontend_pkg::OPC_JAL:    cls = frontend_pkg::jal;
            frontend_pkg::OPC_JALR:   cls = frontend_pkg::jalr;
            frontend_pkg::OPC_LUI:    cls = frontend_pkg::lui;
            frontend_pkg::OPC_AUIPC:  cls = frontend_pkg::auipc;
            frontend_pkg::OPC_SYSTEM: cls = frontend_pkg::system;
            default:                  cls = frontend_pkg::illegal;
        endcase

        case (cls)
            frontend_pkg::alu_imm,
            frontend_pkg::load,
            frontend_pkg::jalr:   imm = {{20{w[31]}}, w[31:20]};
            frontend_pkg::store:  imm = {{20{w[31]}}, w[31:25], w[11:7]};
            frontend_pkg::branch: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            frontend_pkg::lui,
            frontend_pkg::auipc:  imm = {w[31:12], 12'b0};
            frontend_pkg::jal:    imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:              imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (redirect) begin
            dec_valid <= 1'b0;
        end else if (deq.pop) begin
            dec_valid <= 1'b1;
        end else if (issue_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // Fields only move on a pop, so they hold under back-pressure.
    always_ff @(posedge clk) begin
        if (deq.pop) begin
            dec_pc    <= deq.head_pc;
            dec_class <= cls;
            dec_rd    <= w[11:7];
            dec_rs1   <= w[19:15];
            dec_rs2   <= w[24:20];
            dec_imm   <= imm;
        end
    end

    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid && !issue_ready && !redirect |=>
            dec_valid && $stable(dec_pc) && $stable(dec_class) && $stable(dec_rd) &&
            $stable(dec_rs1) && $stable(dec_rs2) && $stable(dec_imm)
    );

endmodule

// ==== source/fetch_if.sv ====
`timescale 1ns/100ps

interface fetch_if;

    // Request from the queue, one cycle wide.
    logic                 req;
    frontend_pkg::pc_t    req_pc;

    // Answer from the cache.
    logic                 hit;
    frontend_pkg::instr_t instr;

    modport cache (input req, input req_pc, output hit, output instr);

    modport queue (output req, output req_pc, input hit, input instr);

endinterface

// ==== source/frontend_pkg.sv ====
package frontend_pkg;

    // ######################################
    // Widths
    // ######################################
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    typedef logic [6:0]  opcode_t;

    localparam pc_t RESET_PC = 32'h0000_0000;

    // Queue pointers carry one wrap bit above the index.
    localparam int IQ_DEPTH = 16;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    typedef logic [IQ_PTR_W:0] iq_ptr_t;

    // Index is pc[5:2], tag is pc[31:6].
    localparam int ICACHE_LINES = 16;
    localparam int ICACHE_IDX_W = $clog2(ICACHE_LINES);
    localparam int ICACHE_TAG_W = 32 - ICACHE_IDX_W - 2;
    typedef logic [ICACHE_IDX_W-1:0] icache_idx_t;
    typedef logic [ICACHE_TAG_W-1:0] icache_tag_t;

    // ######################################
    // RV32I major opcodes
    // ######################################
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        alu_reg, alu_imm, load, store, branch, jal, jalr, lui, auipc, system, illegal
    } op_class_e;

    typedef enum logic [1:0] {
        idle, lookup, refill
    } icache_state_e;

endpackage

// ==== source/frontend_top.sv ====
`timescale 1ns/100ps

module frontend_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  frontend_pkg::pc_t       redirect_pc,
    input  logic                    issue_ready,
    input  logic                    mem_valid,
    input  frontend_pkg::instr_t    mem_data,
    output logic                    mem_req,
    output frontend_pkg::pc_t       mem_addr,
    output logic                    dec_valid,
    output frontend_pkg::pc_t       dec_pc,
    output frontend_pkg::op_class_e dec_class,
    output frontend_pkg::reg_idx_t  dec_rd,
    output frontend_pkg::reg_idx_t  dec_rs1,
    output frontend_pkg::reg_idx_t  dec_rs2,
    output frontend_pkg::imm_t      dec_imm
);

    fetch_if  fetch_bus ();
    decode_if deq_bus ();

    // ######################################
    // Cache, queue, decode
    // ######################################
    icache u_icache (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .fetch     (fetch_bus.cache),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

    instr_queue u_instr_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch       (fetch_bus.queue),
        .deq         (deq_bus.queue)
    );

    decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .issue_ready (issue_ready),
        .deq         (deq_bus.dec),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_class   (dec_class),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm)
    );

endmodule

// ==== source/icache.sv ====
`timescale 1ns/100ps

module icache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 redirect,
    fetch_if.cache               fetch,
    output logic                 mem_req,
    output frontend_pkg::pc_t    mem_addr,
    input  logic                 mem_valid,
    input  frontend_pkg::instr_t mem_data
);

    frontend_pkg::icache_state_e state;
    frontend_pkg::pc_t           look_pc;
    frontend_pkg::pc_t           pend_pc;
    logic                        pend;
    logic                        drop;
    logic [frontend_pkg::ICACHE_LINES-1:0] line_valid;
    frontend_pkg::icache_tag_t   tag_mem [frontend_pkg::ICACHE_LINES];
    frontend_pkg::instr_t        data_mem [frontend_pkg::ICACHE_LINES];
    frontend_pkg::icache_idx_t   look_idx;
    frontend_pkg::icache_tag_t   look_tag;
    logic                        line_hit;
    logic                        take_req;

    assign look_idx = look_pc[frontend_pkg::ICACHE_IDX_W+1:2];
    assign look_tag = look_pc[31:frontend_pkg::ICACHE_IDX_W+2];
    assign line_hit = line_valid[look_idx] && (tag_mem[look_idx] == look_tag);
    assign take_req = fetch.req && !redirect;

    assign fetch.hit   = (state == frontend_pkg::lookup) && line_hit;
    assign fetch.instr = data_mem[look_idx];

    // Miss shows up on mem_req in the lookup cycle itself.
    assign mem_req  = (state == frontend_pkg::refill) ||
                      ((state == frontend_pkg::lookup) && !line_hit);
    assign mem_addr = look_pc;

    // ######################################
    // Lookup and refill FSM
    // ######################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= frontend_pkg::idle;
            look_pc    <= frontend_pkg::RESET_PC;
            pend       <= 1'b0;
            drop       <= 1'b0;
            line_valid <= '0;
        end else begin
            if (redirect) begin
                pend <= 1'b0;
            end
            case (state)
                frontend_pkg::idle: begin
                    if (pend && !redirect) begin
                        look_pc <= pend_pc;
                        pend    <= 1'b0;
                        state   <= frontend_pkg::lookup;
                    end else if (take_req) begin
                        look_pc <= fetch.req_pc;
                        state   <= frontend_pkg::lookup;
                    end
                end
                frontend_pkg::lookup: begin
                    if (line_hit) begin
                        state <= frontend_pkg::idle;
                    end else if (mem_valid) begin
                        // Memory answered in the miss cycle, so the hit follows next cycle.
                        line_valid[look_idx] <= 1'b1;
                        if (redirect) begin
                            state <= frontend_pkg::idle;
                        end
                    end else begin
                        // A miss seen during a redirect still refills.
                        state <= frontend_pkg::refill;
                        drop  <= redirect;
                    end
                end
                frontend_pkg::refill: begin
                    if (redirect) begin
                        drop <= 1'b1;
                    end
                    // Only a request from the new stream can land here.
                    if (take_req) begin
                        pend <= 1'b1;
                    end
                    if (mem_valid) begin
                        line_valid[look_idx] <= 1'b1;
                        if (drop || redirect) begin
                            state <= frontend_pkg::idle;
                        end else begin
                            state <= frontend_pkg::lookup;
                        end
                    end
                end
                default: state <= frontend_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req && mem_valid) begin
            tag_mem[look_idx]  <= look_tag;
            data_mem[look_idx] <= mem_data;
        end
        if ((state == frontend_pkg::refill) && take_req) begin
            pend_pc <= fetch.req_pc;
        end
    end

    a_mem_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req && !mem_valid |=> mem_req && $stable(mem_addr)
    );

endmodule

// ==== source/instr_queue.sv ====
`timescale 1ns/100ps

module instr_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              redirect,
    input  frontend_pkg::pc_t redirect_pc,
    fetch_if.queue            fetch,
    decode_if.queue           deq
);

    frontend_pkg::iq_ptr_t wr_ptr;
    frontend_pkg::iq_ptr_t rd_ptr;
    frontend_pkg::pc_t     fetch_pc;
    logic                  outstanding;
    logic                  fetch_en;
    logic                  full;
    frontend_pkg::instr_t  instr_mem [frontend_pkg::IQ_DEPTH];
    frontend_pkg::pc_t     pc_mem [frontend_pkg::IQ_DEPTH];

    // Same index with different wrap bits means every slot is taken.
    assign full = (wr_ptr[frontend_pkg::IQ_PTR_W] != rd_ptr[frontend_pkg::IQ_PTR_W]) &&
                  (wr_ptr[frontend_pkg::IQ_PTR_W-1:0] == rd_ptr[frontend_pkg::IQ_PTR_W-1:0]);

    assign deq.empty      = (wr_ptr == rd_ptr);
    assign deq.head_pc    = pc_mem[rd_ptr[frontend_pkg::IQ_PTR_W-1:0]];
    assign deq.head_instr = instr_mem[rd_ptr[frontend_pkg::IQ_PTR_W-1:0]];

    // One fetch in flight at a time.
    assign fetch.req    = fetch_en && !outstanding && !full;
    assign fetch.req_pc = fetch_pc;

    // ######################################
    // Pointers and fetch address
    // ######################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fetch_pc    <= frontend_pkg::RESET_PC;
            outstanding <= 1'b0;
            fetch_en    <= 1'b0;
        end else begin
            // Hold off the first request until the cycle after reset.
            fetch_en <= 1'b1;
            if (redirect) begin
                wr_ptr      <= '0;
                rd_ptr      <= '0;
                fetch_pc    <= redirect_pc;
                outstanding <= 1'b0;
            end else begin
                if (fetch.req) begin
                    outstanding <= 1'b1;
                end
                if (fetch.hit) begin
                    outstanding <= 1'b0;
                    wr_ptr      <= wr_ptr + 1'b1;
                    fetch_pc    <= fetch_pc + 32'd4;
                end
                if (deq.pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // Each word is stored with the address it came from.
    always_ff @(posedge clk) begin
        if (fetch.hit && !redirect) begin
            instr_mem[wr_ptr[frontend_pkg::IQ_PTR_W-1:0]] <= fetch.instr;
            pc_mem[wr_ptr[frontend_pkg::IQ_PTR_W-1:0]]    <= fetch_pc;
        end
    end

    a_no_hit_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.hit |-> !full
    );

endmodule

// ==== test/frontend_checker.sv ====
`timescale 1ns/100ps

module frontend_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  frontend_pkg::pc_t       redirect_pc,
    input  logic                    issue_ready,
    input  logic                    mem_req,
    input  frontend_pkg::pc_t       mem_addr,
    input  logic                    mem_valid,
    input  logic                    dec_valid,
    input  frontend_pkg::pc_t       dec_pc,
    input  frontend_pkg::op_class_e dec_class,
    input  logic [4:0]              dec_rd,
    input  logic [4:0]              dec_rs1,
    input  logic [4:0]              dec_rs2,
    input  logic [31:0]             dec_imm,
    output int                      errors
);

    frontend_pkg::instr_t    image [frontend_pkg::pc_t];
    frontend_pkg::pc_t       expect_pc;
    frontend_pkg::op_class_e exp_class;
    logic [31:0]             exp_imm;
    frontend_pkg::instr_t    w;
    logic [25:0]             line_tag [16];
    logic [15:0]             line_ok;
    logic                    seen_req;
    logic                    prev_valid;
    logic                    prev_ready;
    logic                    prev_redirect;
    logic                    prev_mreq;
    logic                    prev_mvalid;
    logic [82:0]             prev_fields;

    function automatic frontend_pkg::instr_t word_at(input frontend_pkg::pc_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return (a * 32'h9e37_79b1) ^ 32'h0000_0013;
    endfunction

    // RV32I base opcodes and immediate layouts.
    function automatic void ref_decode(input frontend_pkg::instr_t i,
                                       output frontend_pkg::op_class_e c,
                                       output logic [31:0] imm);
        case (i[6:0])
            7'h33: c = frontend_pkg::alu_reg;
            7'h13: c = frontend_pkg::alu_imm;
            7'h03: c = frontend_pkg::load;
            7'h23: c = frontend_pkg::store;
            7'h63: c = frontend_pkg::branch;
            7'h6f: c = frontend_pkg::jal;
            7'h67: c = frontend_pkg::jalr;
            7'h37: c = frontend_pkg::lui;
            7'h17: c = frontend_pkg::auipc;
            7'h73: c = frontend_pkg::system;
            default: c = frontend_pkg::illegal;
        endcase
        imm = 32'h0;
        if (c == frontend_pkg::alu_imm || c == frontend_pkg::load || c == frontend_pkg::jalr)
            imm = {{20{i[31]}}, i[31:20]};
        if (c == frontend_pkg::store)
            imm = {{20{i[31]}}, i[31:25], i[11:7]};
        if (c == frontend_pkg::branch)
            imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        if (c == frontend_pkg::lui || c == frontend_pkg::auipc)
            imm = {i[31:12], 12'h000};
        if (c == frontend_pkg::jal)
            imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    initial begin
        int    fd;
        string line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        errors = 0;
        fd = $fopen("test/frontend_stim.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open the stim file");
            errors = errors + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) == "M") begin
                    if ($sscanf(line, "%c %h %h", kind, a, b) == 3) begin
                        image[a] = b;
                    end
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            if (mem_req || dec_valid) begin
                $display("FAIL %0t: mem_req or dec_valid high during reset", $time);
                errors = errors + 1;
            end
            expect_pc = frontend_pkg::RESET_PC;
            line_ok = '0;
            seen_req = 1'b0;
            prev_valid = 1'b0;
            prev_mreq = 1'b0;
            prev_mvalid = 1'b0;
        end else begin
            // ########################################
            // Decode stream
            // ########################################
            if (prev_valid && !prev_ready && !prev_redirect &&
                (!dec_valid || prev_fields != {dec_pc, dec_class, dec_rd, dec_rs1, dec_rs2,
                                               dec_imm})) begin
                $display("FAIL %0t: decode outputs moved while stalled", $time);
                errors = errors + 1;
            end
            if (redirect) begin
                expect_pc = redirect_pc;
            end else if (dec_valid && issue_ready) begin
                w = word_at(expect_pc);
                ref_decode(w, exp_class, exp_imm);
                if (dec_pc != expect_pc) begin
                    $display("FAIL %0t: dec_pc %h expected %h", $time, dec_pc, expect_pc);
                    errors = errors + 1;
                end else if (dec_class != exp_class || dec_imm != exp_imm ||
                             dec_rd != w[11:7] || dec_rs1 != w[19:15] ||
                             dec_rs2 != w[24:20]) begin
                    $display("FAIL %0t: bad decode at %h, class %0d imm %h expected %0d %h",
                             $time, dec_pc, dec_class, dec_imm, exp_class, exp_imm);
                    errors = errors + 1;
                end
                expect_pc = expect_pc + 32'd4;
            end

            // ########################################
            // Cache line model
            // ########################################
            if (mem_req && (!prev_mreq || prev_mvalid)) begin
                if (!seen_req && mem_addr != frontend_pkg::RESET_PC) begin
                    $display("FAIL %0t: first mem_addr %h is not the reset address",
                             $time, mem_addr);
                    errors = errors + 1;
                end
                seen_req = 1'b1;
                if (line_ok[mem_addr[5:2]] && line_tag[mem_addr[5:2]] == mem_addr[31:6]) begin
                    $display("FAIL %0t: refill of cached address %h", $time, mem_addr);
                    errors = errors + 1;
                end
            end
            if (mem_req && mem_valid) begin
                line_ok[mem_addr[5:2]] = 1'b1;
                line_tag[mem_addr[5:2]] = mem_addr[31:6];
            end
            prev_valid = dec_valid;
            prev_ready = issue_ready;
            prev_redirect = redirect;
            prev_mreq = mem_req;
            prev_mvalid = mem_valid;
            prev_fields = {dec_pc, dec_class, dec_rd, dec_rs1, dec_rs2, dec_imm};
        end
    end

endmodule

// ==== test/frontend_stim.txt ====
// kind a b, all values hex
// M addr word | X accepted_count redirect_pc | S accepted_count stall_cycles
M 00000000 00500093
M 00000004 00a00113
M 00000008 002081b3
M 0000000c 0001a203
M 00000010 0041a423
M 00000014 fe208ee3
M 00000018 123452b7
M 0000001c 00001317
M 00000020 008000ef
M 00000024 000080e7
M 00000028 00000073
M 0000002c 00000000
M 00000030 ffffffff
M 00000034 80000393
S 00000006 00000014
X 00000010 00000000
S 00000018 00000020
X 0000001c 00000008
X 00000028 00000040
X 00000030 00000000
S 00000034 00000010

// ==== test/frontend_tb.sv ====
`timescale 1ns/100ps

module frontend_tb;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    redirect;
    frontend_pkg::pc_t       redirect_pc;
    logic                    issue_ready;
    logic                    mem_valid;
    frontend_pkg::instr_t    mem_data;
    logic                    mem_req;
    frontend_pkg::pc_t       mem_addr;
    logic                    dec_valid;
    frontend_pkg::pc_t       dec_pc;
    frontend_pkg::op_class_e dec_class;
    frontend_pkg::reg_idx_t  dec_rd;
    frontend_pkg::reg_idx_t  dec_rs1;
    frontend_pkg::reg_idx_t  dec_rs2;
    frontend_pkg::imm_t      dec_imm;
    int                      errors;

    frontend_pkg::instr_t image [frontend_pkg::pc_t];
    logic [7:0]  ev_kind [$];
    int          ev_count [$];
    logic [31:0] ev_value [$];
    int          words = 0;
    int          stall_total = 0;
    int          accepted = 0;
    int          lat = 0;
    logic        loaded = 1'b0;

    always #5 clk = ~clk;

    frontend_top UUT (.*);

    frontend_checker checker_i (.*);

    // Addresses outside the image still return a word.
    function automatic frontend_pkg::instr_t word_at(input frontend_pkg::pc_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return (a * 32'h9e37_79b1) ^ 32'h0000_0013;
    endfunction

    task automatic load_stim(output logic ok);
        int    fd;
        string line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("test/frontend_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/frontend_stim.txt");
            ok = 1'b0;
        end else begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) != "/" &&
                    $sscanf(line, "%c %h %h", kind, a, b) == 3) begin
                    if (kind == "M") begin
                        image[a] = b;
                        words = words + 1;
                    end else begin
                        ev_kind.push_back(kind);
                        ev_count.push_back(int'(a));
                        ev_value.push_back(b);
                        if (kind == "S") stall_total = stall_total + int'(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Memory answers after a random latency.
    always @(posedge clk) begin
        #1;
        if (mem_valid) begin
            mem_valid = 1'b0;
        end else if (mem_req) begin
            if (lat == 0) lat = int'($urandom_range(4, 1));
            lat = lat - 1;
            if (lat == 0) begin
                mem_valid = 1'b1;
                mem_data = word_at(mem_addr);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && dec_valid && issue_ready && !redirect) accepted = accepted + 1;
    end

    initial begin
        wait (loaded);
        repeat (200 * words + stall_total) @(posedge clk);
        $display("Watchdog expired after %0d accepted instructions", accepted);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int   stall_left;
        int   last_count;
        logic stim_ok;
        void'($urandom(32'h1fab));
        rst_n = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        issue_ready = 1'b0;
        mem_valid = 1'b0;
        mem_data = '0;
        stall_left = 0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("Simulation failed");
        end else begin
            last_count = (ev_count.size() > 0) ? ev_count[ev_count.size()-1] : 0;
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            #1 rst_n = 1'b1;
            while (accepted < last_count + 24) begin
                @(posedge clk);
                #1;
                redirect = 1'b0;
                if (stall_left > 0) stall_left = stall_left - 1;
                if (ev_kind.size() > 0 && accepted >= ev_count[0]) begin
                    if (ev_kind[0] == "X") begin
                        redirect = 1'b1;
                        redirect_pc = ev_value[0];
                    end else begin
                        stall_left = int'(ev_value[0]);
                    end
                    void'(ev_kind.pop_front());
                    void'(ev_count.pop_front());
                    void'(ev_value.pop_front());
                end
                issue_ready = !redirect && stall_left == 0 && $urandom_range(7, 0) != 0;
            end
            repeat (4) @(posedge clk);
            $display("Errors: %0d, accepted instructions: %0d", errors, accepted);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule
